// File: verilog/cpu_pkg.sv
package cpu_pkg;

    // RV32I major opcodes for the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_SLT = 4'd5
    } alu_func_t;

    // ALU operand sources
    typedef enum logic [1:0] {
        OPSEL_REG  = 2'd0,
        OPSEL_PC   = 2'd1,
        OPSEL_IMM  = 2'd2,
        OPSEL_ZERO = 2'd3
    } opsel_t;

    // Register file write value sources
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LOAD = 2'd1,
        WB_IMM  = 2'd2,
        WB_PC4  = 2'd3
    } wbsel_t;

    // Bit 0 set means branch or jump taken
    typedef enum logic [1:0] {
        PC_SEQ   = 2'b00,
        PC_TAKEN = 2'b01
    } pcsel_t;

endpackage

// File: verilog/fetch.sv
`timescale 1ns/100ps

module fetch import cpu_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             stall_i,
    input  logic             flush_i,
    input  pcsel_t           pcsel_i,
    input  logic [WIDTH-1:0] br_tar_i,
    input  logic [31:0]      instr_i,
    output logic [WIDTH-1:0] pc_o,
    output logic [WIDTH-1:0] pc_id_o,
    output logic [31:0]      instr_id_o,
    output logic             valid_id_o
);

    logic [WIDTH-1:0] pc_next;

    // Target from execute wins over the sequential PC
    assign pc_next = pcsel_i[0] ? br_tar_i : pc_o + WIDTH'(4);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_o <= '0;
        end else if (!stall_i) begin
            pc_o <= pc_next;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_id_o <= 1'b0;
        end else if (flush_i) begin
            valid_id_o <= 1'b0;
        end else if (!stall_i) begin
            valid_id_o <= 1'b1;
        end
    end

    // Fetch/decode payload, held while decode is stalled
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            pc_id_o    <= pc_o;
            instr_id_o <= instr_i;
        end
    end

endmodule

// File: verilog/decode.sv
`timescale 1ns/100ps

module decode import cpu_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             stall_i,
    input  logic             flush_i,
    input  logic [WIDTH-1:0] pc_i,
    input  logic [31:0]      instr_i,
    input  logic             valid_i,
    input  logic [WIDTH-1:0] rs1_data_i,
    input  logic [WIDTH-1:0] rs2_data_i,
    output logic [4:0]       rs1_addr_o,
    output logic [4:0]       rs2_addr_o,
    output logic             uses_rs1_o,
    output logic             uses_rs2_o,
    output logic [WIDTH-1:0] pc_o,
    output logic [WIDTH-1:0] rs1_data_o,
    output logic [WIDTH-1:0] rs2_data_o,
    output logic [WIDTH-1:0] imm_o,
    output logic [4:0]       rd_addr_o,
    output alu_func_t        alu_func_o,
    output opsel_t           opsel1_o,
    output opsel_t           opsel2_o,
    output wbsel_t           wbsel_o,
    output logic             rf_we_o,
    output logic             mem_we_o,
    output logic             load_o,
    output logic             branch_o,
    output logic             branch_ne_o,
    output logic             jump_o
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [WIDTH-1:0] imm_i;
    logic [WIDTH-1:0] imm_s;
    logic [WIDTH-1:0] imm_b;
    logic [WIDTH-1:0] imm_u;
    logic [WIDTH-1:0] imm_j;
    logic [WIDTH-1:0] imm;
    alu_func_t        alu;
    opsel_t           op1;
    opsel_t           op2;
    wbsel_t           wb;
    logic             known;
    logic             use1;
    logic             use2;
    logic             rf_we;
    logic             mem_we;
    logic             load;
    logic             branch;
    logic             jump;
    logic             bubble;

    assign opcode     = instr_i[6:0];
    assign funct3     = instr_i[14:12];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    // Sign-extended immediates for each format
    assign imm_i = WIDTH'($signed(instr_i[31:20]));
    assign imm_s = WIDTH'($signed({instr_i[31:25], instr_i[11:7]}));
    assign imm_b = WIDTH'($signed({instr_i[31], instr_i[7], instr_i[30:25],
                                   instr_i[11:8], 1'b0}));
    assign imm_u = WIDTH'($signed({instr_i[31:12], 12'b0}));
    assign imm_j = WIDTH'($signed({instr_i[31], instr_i[19:12], instr_i[20],
                                   instr_i[30:21], 1'b0}));

    always_comb begin
        known  = 1'b1;
        imm    = imm_i;
        alu    = ALU_ADD;
        op1    = OPSEL_REG;
        op2    = OPSEL_REG;
        wb     = WB_ALU;
        use1   = 1'b0;
        use2   = 1'b0;
        rf_we  = 1'b0;
        mem_we = 1'b0;
        load   = 1'b0;
        branch = 1'b0;
        jump   = 1'b0;
        case (opcode)
            OPC_OP: begin
                use1  = 1'b1;
                use2  = 1'b1;
                rf_we = 1'b1;
                case (funct3)
                    3'b000:  alu = instr_i[30] ? ALU_SUB : ALU_ADD;
                    3'b010:  alu = ALU_SLT;
                    3'b100:  alu = ALU_XOR;
                    3'b110:  alu = ALU_OR;
                    3'b111:  alu = ALU_AND;
                    default: known = 1'b0;
                endcase
            end
            OPC_OPIMM: begin
                // ADDI only
                use1  = 1'b1;
                op2   = OPSEL_IMM;
                rf_we = 1'b1;
                known = (funct3 == 3'b000);
            end
            OPC_LUI: begin
                imm   = imm_u;
                wb    = WB_IMM;
                rf_we = 1'b1;
            end
            OPC_LOAD: begin
                use1  = 1'b1;
                op2   = OPSEL_IMM;
                wb    = WB_LOAD;
                rf_we = 1'b1;
                load  = 1'b1;
            end
            OPC_STORE: begin
                use1   = 1'b1;
                use2   = 1'b1;
                imm    = imm_s;
                op2    = OPSEL_IMM;
                mem_we = 1'b1;
            end
            OPC_BRANCH: begin
                // BEQ and BNE only
                use1   = 1'b1;
                use2   = 1'b1;
                imm    = imm_b;
                branch = 1'b1;
                known  = (funct3[2:1] == 2'b00);
            end
            OPC_JAL: begin
                imm   = imm_j;
                wb    = WB_PC4;
                rf_we = 1'b1;
                jump  = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    assign uses_rs1_o = valid_i && use1;
    assign uses_rs2_o = valid_i && use2;

    // Stalls, flushes, empty slots and unknown opcodes all become bubbles
    assign bubble = stall_i || flush_i || !valid_i || !known;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rf_we_o  <= 1'b0;
            mem_we_o <= 1'b0;
            load_o   <= 1'b0;
            branch_o <= 1'b0;
            jump_o   <= 1'b0;
        end else begin
            rf_we_o  <= !bubble && rf_we;
            mem_we_o <= !bubble && mem_we;
            load_o   <= !bubble && load;
            branch_o <= !bubble && branch;
            jump_o   <= !bubble && jump;
        end
    end

    always_ff @(posedge clk) begin
        pc_o        <= pc_i;
        rs1_data_o  <= rs1_data_i;
        rs2_data_o  <= rs2_data_i;
        imm_o       <= imm;
        rd_addr_o   <= instr_i[11:7];
        alu_func_o  <= alu;
        opsel1_o    <= op1;
        opsel2_o    <= op2;
        wbsel_o     <= wb;
        branch_ne_o <= funct3[0];
    end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/100ps

module regfile #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic             we_i,
    input  logic [4:0]       rd_addr_i,
    input  logic [WIDTH-1:0] wdata_i,
    input  logic [4:0]       ra_addr_i,
    input  logic [4:0]       rb_addr_i,
    output logic [WIDTH-1:0] ra_data_o,
    output logic [WIDTH-1:0] rb_data_o
);

    // x0 has no storage
    logic [WIDTH-1:0] regs [1:31];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_addr_i != 5'd0) begin
            regs[rd_addr_i] <= wdata_i;
        end
    end

    assign ra_data_o = (ra_addr_i == 5'd0) ? '0 : regs[ra_addr_i];
    assign rb_data_o = (rb_addr_i == 5'd0) ? '0 : regs[rb_addr_i];

endmodule

// File: verilog/hazard_detect.sv
`timescale 1ns/100ps

module hazard_detect (
    input  logic [4:0] rs1_addr_i,
    input  logic [4:0] rs2_addr_i,
    input  logic       uses_rs1_i,
    input  logic       uses_rs2_i,
    input  logic [4:0] rd_ex_i,
    input  logic       rf_we_ex_i,
    input  logic [4:0] rd_mem_i,
    input  logic       rf_we_mem_i,
    input  logic [4:0] rd_wb_i,
    input  logic       rf_we_wb_i,
    input  logic       taken_ex_i,
    output logic       stall_o,
    output logic       flush_o
);

    logic rs1_hit;
    logic rs2_hit;

    // Source still waiting on a write from an older instruction
    assign rs1_hit = uses_rs1_i && (rs1_addr_i != 5'd0) &&
                     ((rf_we_ex_i  && (rs1_addr_i == rd_ex_i))  ||
                      (rf_we_mem_i && (rs1_addr_i == rd_mem_i)) ||
                      (rf_we_wb_i  && (rs1_addr_i == rd_wb_i)));

    assign rs2_hit = uses_rs2_i && (rs2_addr_i != 5'd0) &&
                     ((rf_we_ex_i  && (rs2_addr_i == rd_ex_i))  ||
                      (rf_we_mem_i && (rs2_addr_i == rd_mem_i)) ||
                      (rf_we_wb_i  && (rs2_addr_i == rd_wb_i)));

    // A taken branch squashes the waiting instruction, so flush wins
    assign flush_o = taken_ex_i;
    assign stall_o = (rs1_hit || rs2_hit) && !taken_ex_i;

endmodule

// File: verilog/execute.sv
`timescale 1ns/100ps

module execute import cpu_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic [WIDTH-1:0] pc_i,
    input  logic [WIDTH-1:0] rs1_data_i,
    input  logic [WIDTH-1:0] rs2_data_i,
    input  logic [WIDTH-1:0] imm_i,
    input  logic [4:0]       rd_addr_i,
    input  alu_func_t        alu_func_i,
    input  opsel_t           opsel1_i,
    input  opsel_t           opsel2_i,
    input  wbsel_t           wbsel_i,
    input  logic             rf_we_i,
    input  logic             mem_we_i,
    input  logic             load_i,
    input  logic             branch_i,
    input  logic             branch_ne_i,
    input  logic             jump_i,
    output pcsel_t           pcsel_o,
    output logic [WIDTH-1:0] br_tar_o,
    output logic [WIDTH-1:0] pc_o,
    output logic [WIDTH-1:0] alu_out_o,
    output logic [WIDTH-1:0] rs2_data_o,
    output logic [WIDTH-1:0] imm_o,
    output logic [4:0]       rd_addr_o,
    output wbsel_t           wbsel_o,
    output logic             rf_we_o,
    output logic             mem_we_o
);

    alu_func_t        func;
    logic [WIDTH-1:0] opa;
    logic [WIDTH-1:0] opb;
    logic [WIDTH-1:0] alu_out;
    logic             taken;

    function automatic logic [WIDTH-1:0] pick_operand(
        input opsel_t           sel,
        input logic [WIDTH-1:0] reg_val
    );
        case (sel)
            OPSEL_REG: return reg_val;
            OPSEL_PC:  return pc_i;
            OPSEL_IMM: return imm_i;
            default:   return '0;
        endcase
    endfunction

    // Address generation for loads and stores always adds
    assign func = (load_i || mem_we_i) ? ALU_ADD : alu_func_i;

    always_comb begin
        opa = pick_operand(opsel1_i, rs1_data_i);
        opb = pick_operand(opsel2_i, rs2_data_i);
        case (func)
            ALU_SUB: alu_out = opa - opb;
            ALU_AND: alu_out = opa & opb;
            ALU_OR:  alu_out = opa | opb;
            ALU_XOR: alu_out = opa ^ opb;
            ALU_SLT: alu_out = WIDTH'($signed(opa) < $signed(opb));
            default: alu_out = opa + opb;
        endcase
    end

    // BNE inverts the equality test
    assign taken    = jump_i || (branch_i && ((rs1_data_i == rs2_data_i) ^ branch_ne_i));
    assign pcsel_o  = taken ? PC_TAKEN : PC_SEQ;
    assign br_tar_o = pc_i + imm_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rf_we_o  <= 1'b0;
            mem_we_o <= 1'b0;
        end else begin
            rf_we_o  <= rf_we_i;
            mem_we_o <= mem_we_i;
        end
    end

    always_ff @(posedge clk) begin
        pc_o       <= pc_i;
        alu_out_o  <= alu_out;
        rs2_data_o <= rs2_data_i;
        imm_o      <= imm_i;
        rd_addr_o  <= rd_addr_i;
        wbsel_o    <= wbsel_i;
    end

endmodule

// File: verilog/memory_access.sv
`timescale 1ns/100ps

module memory_access import cpu_pkg::*; #(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             arst_n_i,
    input  logic [WIDTH-1:0] pc_i,
    input  logic [WIDTH-1:0] alu_out_i,
    input  logic [WIDTH-1:0] dmem_rdata_i,
    input  logic [WIDTH-1:0] imm_i,
    input  logic [4:0]       rd_addr_i,
    input  wbsel_t           wbsel_i,
    input  logic             rf_we_i,
    output logic [4:0]       rd_addr_o,
    output logic             rf_we_o,
    output logic [WIDTH-1:0] rf_wdata_o
);

    logic [WIDTH-1:0] pc4_wb;
    logic [WIDTH-1:0] alu_wb;
    logic [WIDTH-1:0] load_wb;
    logic [WIDTH-1:0] imm_wb;
    wbsel_t           wbsel_wb;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rf_we_o <= 1'b0;
        end else begin
            rf_we_o <= rf_we_i;
        end
    end

    // Link value computed here so execute only carries the PC
    always_ff @(posedge clk) begin
        rd_addr_o <= rd_addr_i;
        wbsel_wb  <= wbsel_i;
        pc4_wb    <= pc_i + WIDTH'(4);
        alu_wb    <= alu_out_i;
        load_wb   <= dmem_rdata_i;
        imm_wb    <= imm_i;
    end

    always_comb begin
        case (wbsel_wb)
            WB_LOAD: rf_wdata_o = load_wb;
            WB_IMM:  rf_wdata_o = imm_wb;
            WB_PC4:  rf_wdata_o = pc4_wb;
            default: rf_wdata_o = alu_wb;
        endcase
    end

endmodule

// File: verilog/cpu.sv
`timescale 1ns/100ps

module cpu import cpu_pkg::*; #(
    parameter int WIDTH      = 32,
    parameter int DMEM_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic [31:0]                   instr_i,
    input  logic [WIDTH-1:0]              dmem_rdata_i,
    output logic [WIDTH-1:0]              pc_o,
    output logic                          dmem_we_o,
    output logic [$clog2(DMEM_WORDS)-1:0] dmem_addr_o,
    output logic [WIDTH-1:0]              dmem_wdata_o
);

    localparam int DADDR_W = $clog2(DMEM_WORDS);

    logic             stall;
    logic             flush;

    // Fetch/decode
    logic [WIDTH-1:0] pc_id;
    logic [31:0]      instr_id;
    logic             valid_id;
    logic [4:0]       rs1_addr;
    logic [4:0]       rs2_addr;
    logic [WIDTH-1:0] rs1_data;
    logic [WIDTH-1:0] rs2_data;
    logic             uses_rs1;
    logic             uses_rs2;

    // Decode/execute
    logic [WIDTH-1:0] pc_ex;
    logic [WIDTH-1:0] rs1_data_ex;
    logic [WIDTH-1:0] rs2_data_ex;
    logic [WIDTH-1:0] imm_ex;
    logic [4:0]       rd_addr_ex;
    alu_func_t        alu_func_ex;
    opsel_t           opsel1_ex;
    opsel_t           opsel2_ex;
    wbsel_t           wbsel_ex;
    logic             rf_we_ex;
    logic             mem_we_ex;
    logic             load_ex;
    logic             branch_ex;
    logic             branch_ne_ex;
    logic             jump_ex;
    pcsel_t           pcsel;
    logic [WIDTH-1:0] br_tar;

    // Execute/memory
    logic [WIDTH-1:0] pc_mem;
    logic [WIDTH-1:0] alu_out_mem;
    logic [WIDTH-1:0] rs2_data_mem;
    logic [WIDTH-1:0] imm_mem;
    logic [4:0]       rd_addr_mem;
    wbsel_t           wbsel_mem;
    logic             rf_we_mem;
    logic             mem_we_mem;

    // Writeback
    logic [4:0]       rd_addr_wb;
    logic             rf_we_wb;
    logic [WIDTH-1:0] rf_wdata_wb;

    // Byte address to word address
    assign dmem_we_o    = mem_we_mem;
    assign dmem_addr_o  = alu_out_mem[DADDR_W+1:2];
    assign dmem_wdata_o = rs2_data_mem;

    fetch #(.WIDTH(WIDTH)) fetch0 (
        .clk(clk), .arst_n_i(arst_n_i), .stall_i(stall), .flush_i(flush),
        .pcsel_i(pcsel), .br_tar_i(br_tar), .instr_i(instr_i), .pc_o(pc_o),
        .pc_id_o(pc_id), .instr_id_o(instr_id), .valid_id_o(valid_id)
    );

    decode #(.WIDTH(WIDTH)) decode0 (
        .clk(clk), .arst_n_i(arst_n_i), .stall_i(stall), .flush_i(flush),
        .pc_i(pc_id), .instr_i(instr_id), .valid_i(valid_id),
        .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
        .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
        .uses_rs1_o(uses_rs1), .uses_rs2_o(uses_rs2),
        .pc_o(pc_ex), .rs1_data_o(rs1_data_ex), .rs2_data_o(rs2_data_ex),
        .imm_o(imm_ex), .rd_addr_o(rd_addr_ex), .alu_func_o(alu_func_ex),
        .opsel1_o(opsel1_ex), .opsel2_o(opsel2_ex), .wbsel_o(wbsel_ex),
        .rf_we_o(rf_we_ex), .mem_we_o(mem_we_ex), .load_o(load_ex),
        .branch_o(branch_ex), .branch_ne_o(branch_ne_ex), .jump_o(jump_ex)
    );

    regfile #(.WIDTH(WIDTH)) regfile0 (
        .clk(clk), .arst_n_i(arst_n_i), .we_i(rf_we_wb), .rd_addr_i(rd_addr_wb),
        .wdata_i(rf_wdata_wb), .ra_addr_i(rs1_addr), .rb_addr_i(rs2_addr),
        .ra_data_o(rs1_data), .rb_data_o(rs2_data)
    );

    hazard_detect hazard0 (
        .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
        .uses_rs1_i(uses_rs1), .uses_rs2_i(uses_rs2),
        .rd_ex_i(rd_addr_ex), .rf_we_ex_i(rf_we_ex),
        .rd_mem_i(rd_addr_mem), .rf_we_mem_i(rf_we_mem),
        .rd_wb_i(rd_addr_wb), .rf_we_wb_i(rf_we_wb),
        .taken_ex_i(pcsel[0]), .stall_o(stall), .flush_o(flush)
    );

    execute #(.WIDTH(WIDTH)) exec0 (
        .clk(clk), .arst_n_i(arst_n_i), .pc_i(pc_ex),
        .rs1_data_i(rs1_data_ex), .rs2_data_i(rs2_data_ex), .imm_i(imm_ex),
        .rd_addr_i(rd_addr_ex), .alu_func_i(alu_func_ex),
        .opsel1_i(opsel1_ex), .opsel2_i(opsel2_ex), .wbsel_i(wbsel_ex),
        .rf_we_i(rf_we_ex), .mem_we_i(mem_we_ex), .load_i(load_ex),
        .branch_i(branch_ex), .branch_ne_i(branch_ne_ex), .jump_i(jump_ex),
        .pcsel_o(pcsel), .br_tar_o(br_tar), .pc_o(pc_mem), .alu_out_o(alu_out_mem),
        .rs2_data_o(rs2_data_mem), .imm_o(imm_mem), .rd_addr_o(rd_addr_mem),
        .wbsel_o(wbsel_mem), .rf_we_o(rf_we_mem), .mem_we_o(mem_we_mem)
    );

    memory_access #(.WIDTH(WIDTH)) memaccess0 (
        .clk(clk), .arst_n_i(arst_n_i), .pc_i(pc_mem), .alu_out_i(alu_out_mem),
        .dmem_rdata_i(dmem_rdata_i), .imm_i(imm_mem), .rd_addr_i(rd_addr_mem),
        .wbsel_i(wbsel_mem), .rf_we_i(rf_we_mem), .rd_addr_o(rd_addr_wb),
        .rf_we_o(rf_we_wb), .rf_wdata_o(rf_wdata_wb)
    );

endmodule

// File: verilog/cpu_system.sv
`timescale 1ns/100ps

module cpu_system #(
    parameter int WIDTH      = 32,
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 64
) (
    input  logic                          clk,
    input  logic                          arst_n_i,
    input  logic                          prog_we_i,
    input  logic [$clog2(IMEM_WORDS)-1:0] prog_addr_i,
    input  logic [31:0]                   prog_data_i,
    input  logic [$clog2(DMEM_WORDS)-1:0] dbg_addr_i,
    output logic                          st_we_o,
    output logic [$clog2(DMEM_WORDS)-1:0] st_addr_o,
    output logic [WIDTH-1:0]              st_data_o,
    output logic [WIDTH-1:0]              dbg_data_o
);

    localparam int IADDR_W = $clog2(IMEM_WORDS);
    localparam int DADDR_W = $clog2(DMEM_WORDS);

    logic [31:0]        imem [IMEM_WORDS];
    logic [WIDTH-1:0]   dmem [DMEM_WORDS];
    logic [WIDTH-1:0]   pc;
    logic [31:0]        instr;
    logic               dmem_we;
    logic [DADDR_W-1:0] dmem_addr;
    logic [WIDTH-1:0]   dmem_wdata;

    // Program load is accepted only while the core is held in reset
    always_ff @(posedge clk) begin
        if (prog_we_i && !arst_n_i) begin
            imem[prog_addr_i] <= prog_data_i;
        end
    end

    assign instr = imem[pc[IADDR_W+1:2]];

    always_ff @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr] <= dmem_wdata;
        end
    end

    assign dbg_data_o = dmem[dbg_addr_i];

    // Store port mirrors the core's write strobe
    assign st_we_o   = dmem_we;
    assign st_addr_o = dmem_addr;
    assign st_data_o = dmem_wdata;

    cpu #(.WIDTH(WIDTH), .DMEM_WORDS(DMEM_WORDS)) cpu0 (
        .clk(clk), .arst_n_i(arst_n_i), .instr_i(instr),
        .dmem_rdata_i(dmem[dmem_addr]), .pc_o(pc), .dmem_we_o(dmem_we),
        .dmem_addr_o(dmem_addr), .dmem_wdata_o(dmem_wdata)
    );

endmodule

// File: verif/clk_gen.sv
`timescale 1ns/100ps

module clk_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);

    // Free-running clock, low for the first half period
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

// File: verif/tb_cpu.sv
`timescale 1ns/100ps

module tb_cpu;

    localparam int    WIDTH       = 32;
    localparam int    IMEM_WORDS  = 256;
    localparam int    DMEM_WORDS  = 64;
    localparam int    IADDR_W     = $clog2(IMEM_WORDS);
    localparam int    DADDR_W     = $clog2(DMEM_WORDS);
    localparam int    HALT_ADDR   = 63;
    localparam int    MAX_CYCLES  = 5000;
    localparam string GOLDEN_FILE = "verif/cpu_golden.txt";

    logic               clk;
    logic               arst_n;
    logic               prog_we;
    logic [IADDR_W-1:0] prog_addr;
    logic [31:0]        prog_data;
    logic [DADDR_W-1:0] dbg_addr;
    logic               st_we;
    logic [DADDR_W-1:0] st_addr;
    logic [WIDTH-1:0]   st_data;
    logic [WIDTH-1:0]   dbg_data;

    // Contents of the golden file
    logic [31:0]      prog_words [$];
    string            exp_name [$];
    int               exp_addr [$];
    logic [WIDTH-1:0] exp_data [$];
    int               mem_addr [$];
    logic [WIDTH-1:0] mem_data [$];

    int errors       = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    bit halted       = 1'b0;

    clk_gen #(.PERIOD_NS(40)) u_clk (.clk_o(clk));

    cpu_system #(
        .WIDTH(WIDTH),
        .IMEM_WORDS(IMEM_WORDS),
        .DMEM_WORDS(DMEM_WORDS)
    ) u_dut (
        .clk(clk), .arst_n_i(arst_n), .prog_we_i(prog_we), .prog_addr_i(prog_addr),
        .prog_data_i(prog_data), .dbg_addr_i(dbg_addr), .st_we_o(st_we),
        .st_addr_o(st_addr), .st_data_o(st_data), .dbg_data_o(dbg_data)
    );

    task automatic read_golden();
        int          fd;
        int          got;
        int          i;
        int          addr;
        string       kind;
        string       line;
        string       name;
        logic [31:0] w [4];
        logic [31:0] data;
        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the golden file %s", GOLDEN_FILE);
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind.substr(0, 0) == "#") begin
                got = $fgets(line, fd);
            end else if (kind == "P") begin
                got = $fscanf(fd, "%h %h %h %h", w[0], w[1], w[2], w[3]);
                for (i = 0; i < got; i++) begin
                    prog_words.push_back(w[i]);
                end
            end else if (kind == "S") begin
                got = $fscanf(fd, "%s %d %h", name, addr, data);
                exp_name.push_back(name);
                exp_addr.push_back(addr);
                exp_data.push_back(data);
            end else if (kind == "M") begin
                got = $fscanf(fd, "%d %h", addr, data);
                mem_addr.push_back(addr);
                mem_data.push_back(data);
            end else begin
                $display("Golden file has a line of unknown kind %s", kind);
                errors++;
                got = $fgets(line, fd);
            end
        end
        $fclose(fd);
    endtask

    // Program words go in while the core is held in reset
    task automatic load_program();
        int i;
        for (i = 0; i < prog_words.size() && i < IMEM_WORDS; i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = IADDR_W'(i);
            prog_data = prog_words[i];
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    function automatic void report_test(string name, int bad);
        if (bad == 0) begin
            $display("test %s: PASS", name);
            tests_passed++;
        end else begin
            $display("test %s: FAIL with %0d mismatches", name, bad);
            tests_failed++;
        end
    endfunction

    function automatic int check_store(int idx);
        int bad;
        bad = 0;
        assert (int'(st_addr) == exp_addr[idx]) else begin
            $display("ERROR %s store %0d address: expected %0d, actual %0d",
                     exp_name[idx], idx, exp_addr[idx], st_addr);
            bad++;
        end
        assert (st_data == exp_data[idx]) else begin
            $display("ERROR %s store %0d data: expected %h, actual %h",
                     exp_name[idx], idx, exp_data[idx], st_data);
            bad++;
        end
        errors += bad;
        return bad;
    endfunction

    function automatic bit last_of_test(int idx);
        return (idx == exp_name.size() - 1) || (exp_name[idx + 1] != exp_name[idx]);
    endfunction

    // Follows the store port until the halt store or the cycle limit
    task automatic wait_for_halt();
        int idx;
        int cycles;
        int test_errs;
        idx       = 0;
        cycles    = 0;
        test_errs = 0;
        while (!halted && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
            if (st_we) begin
                if (idx < exp_name.size()) begin
                    test_errs += check_store(idx);
                    if (last_of_test(idx)) begin
                        report_test(exp_name[idx], test_errs);
                        test_errs = 0;
                    end
                    idx++;
                end else begin
                    $display("Unexpected store to word %0d with data %h after the last one",
                             st_addr, st_data);
                    errors++;
                end
                if (int'(st_addr) == HALT_ADDR) begin
                    halted = 1'b1;
                end
            end
        end
        if (!halted) begin
            $display("Timeout: no store to the halt address within %0d cycles", MAX_CYCLES);
            errors++;
        end
        if (idx < exp_name.size()) begin
            $display("Run ended with %0d expected stores never seen", exp_name.size() - idx);
            errors++;
        end
        // Tests cut short count as failed
        while (idx < exp_name.size()) begin
            if (last_of_test(idx)) begin
                report_test(exp_name[idx], 1);
            end
            idx++;
        end
    endtask

    task automatic check_final_memory();
        int i;
        int bad;
        bad = 0;
        for (i = 0; i < mem_addr.size(); i++) begin
            @(negedge clk);
            dbg_addr = DADDR_W'(mem_addr[i]);
            @(negedge clk);
            assert (dbg_data == mem_data[i]) else begin
                $display("ERROR final_mem word %0d: expected %h, actual %h",
                         mem_addr[i], mem_data[i], dbg_data);
                bad++;
            end
        end
        errors += bad;
        report_test("final_mem", bad);
    endtask

    initial begin
        arst_n    = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        dbg_addr  = '0;
        read_golden();
        if (prog_words.size() == 0 || exp_name.size() == 0) begin
            $display("Golden file holds no program or no expected stores");
            errors++;
        end else begin
            load_program();
            // Reset stays low four more cycles after the load
            repeat (4) @(negedge clk);
            arst_n = 1'b1;
            wait_for_halt();
            if (halted) begin
                check_final_memory();
            end
        end
        $display("Tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: verif/cpu_golden.txt
# P: four program words in hex, loaded from instruction word 0 upward
# S: test name, store word address (decimal), store data (hex), in program order
# M: data memory word address (decimal), expected final data (hex)
P 01900093 00a00113 002081b3 40208233
P 0020f2b3 0020e333 0020c3b3 ffb00413
P 001424b3 0080a533 00302023 00402223
P 00502423 00602623 00702823 00902a23
P 00a02c23 00802e23 00700593 00558593
P 00b58633 02c02023 02002683 00168713
P 02e02223 00208463 02102423 00209663
P 02202623 02202823 00108663 02102823
P 02102623 00109463 02202a23 00c007ef
P 02102c23 02102e23 04f02023 12345837
P 67880813 05002223 04402883 05102423
P abcde937 05202623 06300013 04002823
P 00100993 0f302e23 0000006f 00000013
S alu 0 00000023
S alu 1 0000000f
S alu 2 00000008
S alu 3 0000001b
S alu 4 00000013
S alu 5 00000001
S alu 6 00000000
S alu 7 fffffffb
S raw_dep 8 00000018
S load_use 9 00000019
S branch 10 00000019
S branch 13 0000000a
S jal 16 00000090
S lui_mem 17 12345678
S lui_mem 18 12345678
S lui_mem 19 abcde000
S x0_store 20 00000000
S halt 63 00000001
M 0 00000023
M 1 0000000f
M 2 00000008
M 3 0000001b
M 4 00000013
M 5 00000001
M 6 00000000
M 7 fffffffb
M 8 00000018
M 9 00000019
M 10 00000019
M 13 0000000a
M 16 00000090
M 17 12345678
M 18 12345678
M 19 abcde000
M 20 00000000
M 63 00000001

// File: compile.f
verilog/cpu_pkg.sv
verilog/fetch.sv
verilog/decode.sv
verilog/regfile.sv
verilog/hazard_detect.sv
verilog/execute.sv
verilog/memory_access.sv
verilog/cpu.sv
verilog/cpu_system.sv
verif/clk_gen.sv
verif/tb_cpu.sv

// File: Makefile
SIM        := verilator
TOP        := tb_cpu
RTL_TOP    := cpu_system
FILELIST   := compile.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "Regression passed" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
